// File: Makefile
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: background_drawer/background_drawer.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module background_drawer import gfx_types_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    draw_cmd_if.engine                  cmd,
    output logic                        write_en,
    output logic      [`GFX_ADDR_W-1:0] write_addr,
    output color_t                      write_data
);

    localparam int XW    = $clog2(`GFX_WIDTH);
    localparam int YW    = $clog2(`GFX_HEIGHT);
    localparam int ROW_W = $clog2(`GFX_HEIGHT);

    draw_state_t      state;
    logic [XW-1:0]    x;
    logic [YW-1:0]    y;
    logic             start_ok;
    logic             last_x;
    logic             last_pix;
    draw_op_t         op_q;
    color_t           top_q;
    color_t           bottom_q;
    logic [ROW_W-1:0] split_q;

    assign start_ok = (state == DRAW_IDLE) && cmd.start;
    assign last_x   = (x == XW'(`GFX_WIDTH - 1));
    assign last_pix = last_x && (y == YW'(`GFX_HEIGHT - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= DRAW_IDLE;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    if (cmd.start) begin
                        state <= DRAW_ACTIVE;
                    end
                end
                DRAW_ACTIVE: begin
                    if (last_pix) begin
                        state <= DRAW_IDLE;
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    // Raster order, x runs fastest
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x <= '0;
            y <= '0;
        end else if (start_ok) begin
            x <= '0;
            y <= '0;
        end else if (state == DRAW_ACTIVE) begin
            if (last_x) begin
                x <= '0;
                y <= last_pix ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Settings are frozen for the whole frame
    always_ff @(posedge clk) begin
        if (start_ok) begin
            op_q     <= cmd.op;
            top_q    <= cmd.color_top;
            bottom_q <= cmd.color_bottom;
            split_q  <= cmd.split_row;
        end
    end

    assign write_en   = (state == DRAW_ACTIVE);
    assign write_addr = `GFX_ADDR_W'(y) * `GFX_ADDR_W'(`GFX_WIDTH) + `GFX_ADDR_W'(x);

    always_comb begin
        if ((op_q == DRAW_SPLIT) && (y >= split_q)) begin
            write_data = bottom_q;
        end else begin
            write_data = top_q;
        end
    end

    assign cmd.busy = (state == DRAW_ACTIVE);
    assign cmd.done = (state == DRAW_ACTIVE) && last_pix;

endmodule

`default_nettype wire

// File: common/apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

    // Register selects decoded from paddr
    typedef enum logic [2:0] {
        REG_CTRL,
        REG_STATUS,
        REG_COLOR_TOP,
        REG_COLOR_BOTTOM,
        REG_SPLIT_ROW,
        REG_PIX_ADDR,
        REG_PIX_DATA,
        REG_NONE
    } reg_sel_t;

    // STATUS word, busy in bit 0 and done in bit 1
    typedef struct packed {
        logic [29:0] reserved;
        logic        done;
        logic        busy;
    } status_t;

endpackage

`default_nettype wire

// File: common/draw_cmd_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

interface draw_cmd_if import gfx_types_pkg::*; ();

    localparam int ROW_W = $clog2(`GFX_HEIGHT);

    logic             start;
    draw_op_t         op;
    color_t           color_top;
    color_t           color_bottom;
    logic [ROW_W-1:0] split_row;
    logic             busy;
    logic             done;

    modport host (
        output start, op, color_top, color_bottom, split_row,
        input  busy, done
    );

    modport engine (
        input  start, op, color_top, color_bottom, split_row,
        output busy, done
    );

endinterface

`default_nettype wire

// File: common/gfx_consts.svh
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// Frame buffer geometry in pixels
`define GFX_WIDTH   160
`define GFX_HEIGHT  120

// Enough bits to address every pixel of the buffer
`define GFX_ADDR_W  15

// APB register byte offsets
`define GFX_REG_CTRL          8'h00
`define GFX_REG_STATUS        8'h04
`define GFX_REG_COLOR_TOP     8'h08
`define GFX_REG_COLOR_BOTTOM  8'h0C
`define GFX_REG_SPLIT_ROW     8'h10
`define GFX_REG_PIX_ADDR      8'h14
`define GFX_REG_PIX_DATA      8'h18

`endif

// File: common/gfx_types_pkg.sv
`default_nettype none

package gfx_types_pkg;

    typedef logic [7:0] color_red_t;
    typedef logic [7:0] color_green_t;
    typedef logic [7:0] color_blue_t;

    // Red sits in the high byte
    typedef struct packed {
        color_red_t   red;
        color_green_t green;
        color_blue_t  blue;
    } color_t;

    typedef enum logic [0:0] {
        DRAW_FILL  = 1'b0,
        DRAW_SPLIT = 1'b1
    } draw_op_t;

    typedef enum logic [0:0] {
        DRAW_IDLE   = 1'b0,
        DRAW_ACTIVE = 1'b1
    } draw_state_t;

endpackage

`default_nettype wire

// File: frame_buffer/frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module frame_buffer import gfx_types_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   write_en,
    input  wire logic [`GFX_ADDR_W-1:0] write_addr,
    input  wire color_t                 write_data,
    input  wire logic                   read_en,
    input  wire logic [`GFX_ADDR_W-1:0] read_addr,
    output color_t                      read_data
);

    localparam int DEPTH = `GFX_WIDTH * `GFX_HEIGHT;

    color_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Addresses past the last pixel read back as black
    always_ff @(posedge clk) begin
        if (read_en) begin
            if (32'(read_addr) < DEPTH) begin
                read_data <= mem[read_addr];
            end else begin
                read_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module apb_regs import apb_regs_pkg::*, gfx_types_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire logic [7:0]             paddr,
    input  wire logic [31:0]            pwdata,
    output logic      [31:0]            prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        irq,
    draw_cmd_if.host                    cmd,
    output logic                        read_en,
    output logic      [`GFX_ADDR_W-1:0] read_addr,
    input  wire color_t                 read_data
);

    localparam int ROW_W = $clog2(`GFX_HEIGHT);

    reg_sel_t               sel;
    logic                   access;
    logic                   wr_access;
    logic                   rd_access;
    logic                   pix_wait;
    logic                   start_q;
    logic                   done_sticky;
    draw_op_t               op;
    color_t                 color_top;
    color_t                 color_bottom;
    logic [ROW_W-1:0]       split_row;
    logic [`GFX_ADDR_W-1:0] pix_addr;
    status_t                status;

    always_comb begin
        case (paddr)
            `GFX_REG_CTRL:         sel = REG_CTRL;
            `GFX_REG_STATUS:       sel = REG_STATUS;
            `GFX_REG_COLOR_TOP:    sel = REG_COLOR_TOP;
            `GFX_REG_COLOR_BOTTOM: sel = REG_COLOR_BOTTOM;
            `GFX_REG_SPLIT_ROW:    sel = REG_SPLIT_ROW;
            `GFX_REG_PIX_ADDR:     sel = REG_PIX_ADDR;
            `GFX_REG_PIX_DATA:     sel = REG_PIX_DATA;
            default:               sel = REG_NONE;
        endcase
    end

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    // A pixel read spends its first access cycle fetching from the buffer
    assign read_en   = rd_access && (sel == REG_PIX_DATA) && !pix_wait;
    assign read_addr = pix_addr;
    assign pready    = !read_en;
    assign pslverr   = access && (sel == REG_NONE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_wait <= 1'b0;
        end else begin
            pix_wait <= read_en;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op           <= DRAW_FILL;
            color_top    <= '0;
            color_bottom <= '0;
            split_row    <= '0;
            pix_addr     <= '0;
        end else if (wr_access) begin
            case (sel)
                REG_CTRL:         op <= draw_op_t'(pwdata[1]);
                REG_COLOR_TOP:    color_top <= color_t'(pwdata[23:0]);
                REG_COLOR_BOTTOM: color_bottom <= color_t'(pwdata[23:0]);
                REG_SPLIT_ROW:    split_row <= pwdata[ROW_W-1:0];
                REG_PIX_ADDR:     pix_addr <= pwdata[`GFX_ADDR_W-1:0];
                default:          ;
            endcase
        end
    end

    // Start is dropped while a draw is running or already requested
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_q <= 1'b0;
        end else begin
            start_q <= wr_access && (sel == REG_CTRL) && pwdata[0] && !cmd.busy && !start_q;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done_sticky <= 1'b0;
        end else if (cmd.done) begin
            done_sticky <= 1'b1;
        end else if (rd_access && (sel == REG_STATUS)) begin
            done_sticky <= 1'b0;
        end
    end

    assign irq = done_sticky;

    always_comb begin
        status      = '0;
        status.busy = cmd.busy || start_q;
        status.done = done_sticky;
    end

    always_comb begin
        case (sel)
            REG_CTRL:         prdata = {30'b0, op, 1'b0};
            REG_STATUS:       prdata = status;
            REG_COLOR_TOP:    prdata = {8'h00, color_top};
            REG_COLOR_BOTTOM: prdata = {8'h00, color_bottom};
            REG_SPLIT_ROW:    prdata = 32'(split_row);
            REG_PIX_ADDR:     prdata = 32'(pix_addr);
            REG_PIX_DATA:     prdata = {8'h00, read_data};
            default:          prdata = '0;
        endcase
    end

    assign cmd.start        = start_q;
    assign cmd.op           = op;
    assign cmd.color_top    = color_top;
    assign cmd.color_bottom = color_bottom;
    assign cmd.split_row    = split_row;

endmodule

`default_nettype wire

// File: src/gfx_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module gfx_top import gfx_types_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             irq
);

    logic                   write_en;
    logic [`GFX_ADDR_W-1:0] write_addr;
    color_t                 write_data;
    logic                   read_en;
    logic [`GFX_ADDR_W-1:0] read_addr;
    color_t                 read_data;

    draw_cmd_if cmd_bus ();

    apb_regs u_apb_regs (
        .clk       (clk),
        .rstn      (rstn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .irq       (irq),
        .cmd       (cmd_bus.host),
        .read_en   (read_en),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    background_drawer u_background_drawer (
        .clk        (clk),
        .rstn       (rstn),
        .cmd        (cmd_bus.engine),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data)
    );

    frame_buffer u_frame_buffer (
        .clk        (clk),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .read_en    (read_en),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/gfx_types_pkg.sv
common/apb_regs_pkg.sv
common/draw_cmd_if.sv
frame_buffer/frame_buffer.sv
background_drawer/background_drawer.sv
src/apb_regs.sv
src/gfx_top.sv
test/gfx_asserts.sv
test/tb_top.sv

// File: test/gfx_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module gfx_asserts import gfx_types_pkg::*; (
    input wire logic                   clk,
    input wire logic                   rstn,
    input wire logic                   psel,
    input wire logic                   penable,
    input wire logic                   pready,
    input wire draw_state_t            state,
    input wire logic                   write_en,
    input wire logic [`GFX_ADDR_W-1:0] write_addr,
    input wire logic                   done
);

    localparam int PIXELS = `GFX_WIDTH * `GFX_HEIGHT;

    // Wait states only ever appear in the access phase of a pixel read
    pready_idle: assert property (@(posedge clk) disable iff (!rstn)
        !(psel && penable) |-> pready)
        else $error("pready low outside an APB access");

    write_in_active: assert property (@(posedge clk) disable iff (!rstn)
        write_en |-> (state == DRAW_ACTIVE))
        else $error("pixel write outside the active state");

    write_addr_range: assert property (@(posedge clk) disable iff (!rstn)
        32'(write_addr) < PIXELS)
        else $error("pixel write address past the last pixel");

    done_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
        else $error("done held for more than one cycle");

endmodule

// Signals that a block does not have are tied to values that keep those checks quiet
bind apb_regs gfx_asserts apb_asserts_i (
    .clk        (clk),
    .rstn       (rstn),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .state      (DRAW_IDLE),
    .write_en   (1'b0),
    .write_addr ('0),
    .done       (1'b0)
);

bind background_drawer gfx_asserts drawer_asserts_i (
    .clk        (clk),
    .rstn       (rstn),
    .psel       (1'b0),
    .penable    (1'b0),
    .pready     (1'b1),
    .state      (state),
    .write_en   (write_en),
    .write_addr (write_addr),
    .done       (cmd.done)
);

`default_nettype wire

// File: test/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module tb_top;

    localparam int PIXELS = `GFX_WIDTH * `GFX_HEIGHT;
    // Three full draws plus room for the register traffic around them
    localparam int TIMEOUT = 3 * PIXELS + 2000;
    localparam logic [31:0] COLOR_MASK = 32'h00FF_FFFF;
    // Rows 0 to 119 fit in 7 bits
    localparam logic [31:0] ROW_MASK = 32'h0000_007F;
    localparam logic [31:0] ADDR_MASK = (32'd1 << `GFX_ADDR_W) - 1;

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;

    int cycles;
    int done_count;
    int check_count;
    int error_count;
    int test_errors;
    int test_num;

    gfx_top dut_i (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, a draw or bus access never finished", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Drawer completions, sampled between edges
    always @(negedge clk) begin
        if (rstn && dut_i.cmd_bus.done) begin
            done_count = done_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_xfer(1'b1, addr, data, rdata, err, waits);
        check_value("pslverr", 32'(err), 32'h0);
        check_value("write wait states", waits, 0);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        int   waits;
        apb_xfer(1'b0, addr, 32'h0, data, err, waits);
        check_value("pslverr", 32'(err), 32'h0);
        check_value("read wait states", waits, 0);
    endtask

    function automatic logic [31:0] expected_pixel(input int idx, input logic split,
            input logic [31:0] top, input logic [31:0] bottom, input int split_row);
        if (split && (idx / `GFX_WIDTH) >= split_row) begin
            return bottom & COLOR_MASK;
        end
        return top & COLOR_MASK;
    endfunction

    task automatic check_pixel(input int idx, input logic split, input logic [31:0] top,
                               input logic [31:0] bottom, input int split_row);
        logic [31:0] data;
        logic        err;
        int          waits;
        reg_write(`GFX_REG_PIX_ADDR, 32'(idx));
        apb_xfer(1'b0, `GFX_REG_PIX_DATA, 32'h0, data, err, waits);
        check_value("pslverr", 32'(err), 32'h0);
        check_value("pix_data wait states", waits, 1);
        check_value("pix_data", data, expected_pixel(idx, split, top, bottom, split_row));
    endtask

    // First and last pixel, then n random ones
    task automatic check_frame(input logic split, input logic [31:0] top,
                               input logic [31:0] bottom, input int split_row, input int n);
        check_pixel(0, split, top, bottom, split_row);
        check_pixel(PIXELS - 1, split, top, bottom, split_row);
        for (int i = 0; i < n; i++) begin
            check_pixel($urandom_range(PIXELS - 1), split, top, bottom, split_row);
        end
    endtask

    task automatic wait_for_irq();
        @(negedge clk);
        while (!irq) begin
            @(negedge clk);
        end
    endtask

    task automatic check_irq(input logic [31:0] exp);
        @(negedge clk);
        check_value("irq", 32'(irq), exp);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (test_errors == 0) begin
            $display("Test %0d %s: PASS", test_num, name);
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", test_num, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] top;
        logic [31:0] bottom;
        logic [31:0] row;
        logic [31:0] addr;
        logic [31:0] data;
        logic        err;
        int          waits;
        int          split_row;
        int          done_base;

        void'($urandom(32'h75d88a7d));
        clk     = 1'b0;
        rstn    <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= 8'h00;
        pwdata  <= 32'h0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        top    = $urandom();
        bottom = $urandom();
        row    = $urandom();
        addr   = $urandom();
        reg_write(`GFX_REG_COLOR_TOP, top);
        reg_write(`GFX_REG_COLOR_BOTTOM, bottom);
        reg_write(`GFX_REG_SPLIT_ROW, row);
        reg_write(`GFX_REG_PIX_ADDR, addr);
        reg_read(`GFX_REG_COLOR_TOP, data);
        check_value("color_top", data, top & COLOR_MASK);
        reg_read(`GFX_REG_COLOR_BOTTOM, data);
        check_value("color_bottom", data, bottom & COLOR_MASK);
        reg_read(`GFX_REG_SPLIT_ROW, data);
        check_value("split_row", data, row & ROW_MASK);
        reg_read(`GFX_REG_PIX_ADDR, data);
        check_value("pix_addr", data, addr & ADDR_MASK);
        apb_xfer(1'b0, 8'h1C, 32'h0, data, err, waits);
        check_value("pslverr", 32'(err), 32'h1);
        apb_xfer(1'b1, 8'h80, 32'hFFFF_FFFF, data, err, waits);
        check_value("pslverr", 32'(err), 32'h1);
        // STATUS is read only, so this write must leave it clear
        reg_write(`GFX_REG_STATUS, 32'hFFFF_FFFF);
        reg_read(`GFX_REG_STATUS, data);
        check_value("status", data, 32'h0);
        end_test("register readback");

        top = $urandom();
        reg_write(`GFX_REG_COLOR_TOP, top);
        reg_write(`GFX_REG_CTRL, 32'h1);
        reg_read(`GFX_REG_STATUS, data);
        check_value("status", data, 32'h1);
        check_irq(32'h0);
        wait_for_irq();
        check_irq(32'h1);
        reg_read(`GFX_REG_STATUS, data);
        check_value("status", data, 32'h2);
        check_irq(32'h0);
        reg_read(`GFX_REG_STATUS, data);
        check_value("status", data, 32'h0);
        end_test("status and irq");

        check_frame(1'b0, top, 32'h0, 0, 64);
        end_test("fill draw");

        top       = $urandom();
        bottom    = $urandom();
        split_row = $urandom_range(`GFX_HEIGHT - 1, 1);
        reg_write(`GFX_REG_COLOR_TOP, top);
        reg_write(`GFX_REG_COLOR_BOTTOM, bottom);
        reg_write(`GFX_REG_SPLIT_ROW, 32'(split_row));
        reg_write(`GFX_REG_CTRL, 32'h3);
        wait_for_irq();
        reg_read(`GFX_REG_STATUS, data);
        check_value("status", data, 32'h2);
        // Both sides of the boundary row
        check_pixel((split_row - 1) * `GFX_WIDTH + $urandom_range(`GFX_WIDTH - 1),
                    1'b1, top, bottom, split_row);
        check_pixel(split_row * `GFX_WIDTH + $urandom_range(`GFX_WIDTH - 1),
                    1'b1, top, bottom, split_row);
        check_frame(1'b1, top, bottom, split_row, 24);
        end_test("split draw");

        done_base = done_count;
        top       = $urandom();
        bottom    = $urandom();
        split_row = $urandom_range(`GFX_HEIGHT - 1, 1);
        reg_write(`GFX_REG_COLOR_TOP, top);
        reg_write(`GFX_REG_COLOR_BOTTOM, bottom);
        reg_write(`GFX_REG_SPLIT_ROW, 32'(split_row));
        reg_write(`GFX_REG_CTRL, 32'h3);
        repeat (PIXELS / 4) @(posedge clk);
        reg_read(`GFX_REG_STATUS, data);
        check_value("status", data, 32'h1);
        reg_write(`GFX_REG_COLOR_TOP, ~top);
        reg_write(`GFX_REG_COLOR_BOTTOM, ~bottom);
        reg_write(`GFX_REG_CTRL, 32'h1);
        wait_for_irq();
        repeat (40) @(posedge clk);
        reg_read(`GFX_REG_STATUS, data);
        check_value("status", data, 32'h2);
        check_value("done pulses", done_count - done_base, 1);
        check_frame(1'b1, top, bottom, split_row, 16);
        end_test("start while busy");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_num, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
